// File: verilog/rename_config.svh
// Rename stage sizes
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural and physical register file sizes
`define ARCH_REGS 16
`define PHYS_REGS 32

// id widths derived from the register counts above
`define AREG_W 4
`define PREG_W 5

// in-flight instructions held by the retire queue
`define ROB_DEPTH 16

`endif

// File: verilog/rename_pkg.sv
// Rename stage types
`include "rename_config.svh"

package rename_pkg;

  // register ids
  typedef logic [`AREG_W-1:0] areg_t;
  typedef logic [`PREG_W-1:0] preg_t;

  // one instruction presented for renaming
  typedef struct packed {
    logic  has_dest;
    areg_t dest;
    areg_t src1;
    areg_t src2;
  } rename_req_t;

  // renamed operands returned one cycle after acceptance
  // pdest and pold read as zero when the instruction writes no register
  typedef struct packed {
    logic  has_dest;
    preg_t psrc1;
    preg_t psrc2;
    preg_t pdest;
    preg_t pold;
  } rename_rsp_t;

  // what the retire queue needs to free a register at commit
  typedef struct packed {
    logic  has_dest;
    preg_t pold;
  } retire_entry_t;

endpackage

// File: verilog/phys_freelist.sv
// Physical register freelist
`timescale 1ns/1ps
`include "rename_config.svh"

module phys_freelist
  import rename_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_reset_n,

  input  logic  i_push,
  input  preg_t i_push_id,

  input  logic  i_pop,
  output preg_t o_pop_id,

  output logic  o_is_empty
);

  // every non-architectural id can be free at once
  localparam int DEPTH = `PHYS_REGS - `ARCH_REGS;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  preg_t              r_ids [DEPTH];
  logic [PTR_W-1:0]   r_head_ptr;
  logic [PTR_W-1:0]   r_tail_ptr;
  logic [CNT_W-1:0]   r_count;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head_ptr <= '0;
      r_tail_ptr <= '0;
      r_count    <= CNT_W'(DEPTH);
      // the ids above the architectural range start out free, lowest first
      for (int i = 0; i < DEPTH; i++) begin
        r_ids[i] <= preg_t'(`ARCH_REGS + i);
      end
    end else begin
      if (i_push) begin
        r_ids[r_tail_ptr] <= i_push_id;
        r_tail_ptr <= (r_tail_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_tail_ptr + 1'b1;
      end
      if (i_pop) begin
        r_head_ptr <= (r_head_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_head_ptr + 1'b1;
      end
      // a push and a pop together leave the occupancy unchanged
      case ({i_push, i_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  assign o_pop_id   = r_ids[r_head_ptr];
  assign o_is_empty = (r_count == '0);

endmodule

// File: verilog/rename_map.sv
// Speculative register map table
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_map
  import rename_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_reset_n,

  // destination update from an accepted rename
  input  logic  i_wr_en,
  input  areg_t i_wr_areg,
  input  preg_t i_wr_preg,

  // lookups for the instruction being renamed
  input  areg_t i_src1,
  input  areg_t i_src2,
  input  areg_t i_dest,
  output preg_t o_psrc1,
  output preg_t o_psrc2,
  output preg_t o_pold
);

  // one physical id per architectural register
  preg_t r_map [`ARCH_REGS];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      // identity mapping, so register r starts in physical id r
      for (int i = 0; i < `ARCH_REGS; i++) begin
        r_map[i] <= preg_t'(i);
      end
    end else if (i_wr_en) begin
      r_map[i_wr_areg] <= i_wr_preg;
    end
  end

  // reads come straight from the table and so see the contents before
  // this cycle's write, which is what a source equal to its own dest needs
  assign o_psrc1 = r_map[i_src1];
  assign o_psrc2 = r_map[i_src2];

  // previous mapping of the destination, freed when this instruction retires
  assign o_pold = r_map[i_dest];

endmodule

// File: verilog/retire_queue.sv
// In-order retire queue
`timescale 1ns/1ps
`include "rename_config.svh"

module retire_queue
  import rename_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_reset_n,

  // one entry per accepted rename
  input  logic          i_push,
  input  retire_entry_t i_entry,

  // commit of the oldest instruction
  input  logic          i_commit,
  output logic          o_free_valid,
  output preg_t         o_free_id,

  output logic          o_full,
  output logic          o_empty
);

  localparam int DEPTH = `ROB_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  retire_entry_t      r_entries [DEPTH];
  logic [PTR_W-1:0]   r_head_ptr;
  logic [PTR_W-1:0]   r_tail_ptr;
  logic [CNT_W-1:0]   r_count;

  retire_entry_t      head;
  logic               pop;

  assign head = r_entries[r_head_ptr];

  // a commit against an empty queue has nothing to retire
  assign pop = i_commit & ~o_empty;

  // entry storage is written only at the tail
  always_ff @(posedge i_clk) begin
    if (i_push) begin
      r_entries[r_tail_ptr] <= i_entry;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head_ptr <= '0;
      r_tail_ptr <= '0;
      r_count    <= '0;
    end else begin
      if (i_push) begin
        r_tail_ptr <= (r_tail_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_tail_ptr + 1'b1;
      end
      if (pop) begin
        r_head_ptr <= (r_head_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_head_ptr + 1'b1;
      end
      case ({i_push, pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  // the superseded id goes back only if the retiring instruction wrote one
  assign o_free_valid = pop & head.has_dest;
  assign o_free_id    = head.pold;

  assign o_full  = (r_count == CNT_W'(DEPTH));
  assign o_empty = (r_count == '0);

endmodule

// File: verilog/rename_unit.sv
// Register rename stage
`timescale 1ns/1ps

module rename_unit
  import rename_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_reset_n,

  input  logic        i_rename,
  input  rename_req_t i_req,
  input  logic        i_commit,

  output logic        o_stall,
  output logic        o_rsp_valid,
  output rename_rsp_t o_rsp
);

  logic          fl_pop;
  preg_t         fl_pop_id;
  logic          fl_empty;
  logic          free_valid;
  preg_t         free_id;
  logic          rq_full;
  logic          rq_empty;
  logic          accept;
  preg_t         psrc1;
  preg_t         psrc2;
  preg_t         pold;
  retire_entry_t rq_entry;
  rename_rsp_t   rsp_next;

  // stall looks only at state, so a same-cycle commit cannot relieve it
  assign o_stall = rq_full | (i_req.has_dest & fl_empty);
  assign accept  = i_rename & ~o_stall;
  assign fl_pop  = accept & i_req.has_dest;

  phys_freelist u_freelist (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_push     (free_valid),
    .i_push_id  (free_id),
    .i_pop      (fl_pop),
    .o_pop_id   (fl_pop_id),
    .o_is_empty (fl_empty)
  );

  rename_map u_map (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_wr_en   (fl_pop),
    .i_wr_areg (i_req.dest),
    .i_wr_preg (fl_pop_id),
    .i_src1    (i_req.src1),
    .i_src2    (i_req.src2),
    .i_dest    (i_req.dest),
    .o_psrc1   (psrc1),
    .o_psrc2   (psrc2),
    .o_pold    (pold)
  );

  assign rq_entry.has_dest = i_req.has_dest;
  assign rq_entry.pold     = pold;

  retire_queue u_retire (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_push       (accept),
    .i_entry      (rq_entry),
    .i_commit     (i_commit),
    .o_free_valid (free_valid),
    .o_free_id    (free_id),
    .o_full       (rq_full),
    .o_empty      (rq_empty)
  );

  // without a destination the dest fields carry zero rather than stale ids
  assign rsp_next.has_dest = i_req.has_dest;
  assign rsp_next.psrc1    = psrc1;
  assign rsp_next.psrc2    = psrc2;
  assign rsp_next.pdest    = i_req.has_dest ? fl_pop_id : '0;
  assign rsp_next.pold     = i_req.has_dest ? pold : '0;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_rsp_valid <= 1'b0;
    end else begin
      o_rsp_valid <= accept;
    end
  end

  // payload holds its last value between accepted renames
  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_rsp <= rsp_next;
    end
  end

endmodule

// File: verif/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  // reset is held low for four rising edges
  initial begin
    o_reset_n = 1'b0;
    repeat (4) @(posedge o_clk);
    o_reset_n <= 1'b1;
  end

endmodule

// File: verif/rename_checker.sv
// Rename stage scoreboard
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_checker
  import rename_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_reset_n,
  input  logic        i_rename,
  input  rename_req_t i_req,
  input  logic        i_commit,
  input  logic        i_stall,
  input  logic        i_rsp_valid,
  input  rename_rsp_t i_rsp,
  output int          o_errors,
  output int          o_checks
);

  // model state: map table, free ids and in-flight instructions
  preg_t         map_m [`ARCH_REGS];
  preg_t         free_q [$];
  retire_entry_t retire_q [$];

  logic          exp_valid;
  rename_rsp_t   exp_rsp;

  initial begin
    o_errors  = 0;
    o_checks  = 0;
    exp_valid = 1'b0;
    exp_rsp   = '0;
  end

  function automatic void reset_model();
    for (int i = 0; i < `ARCH_REGS; i++) begin
      map_m[i] = preg_t'(i);
    end
    free_q.delete();
    for (int i = `ARCH_REGS; i < `PHYS_REGS; i++) begin
      free_q.push_back(preg_t'(i));
    end
    retire_q.delete();
  endfunction

  // one cycle of the rename stage, given the inputs of that cycle
  function automatic void model_step(
    input  logic        ren,
    input  rename_req_t req,
    input  logic        com,
    output logic        stall,
    output logic        acc,
    output rename_rsp_t rsp
  );
    retire_entry_t entry;
    retire_entry_t head;
    stall = (retire_q.size() == `ROB_DEPTH) || (req.has_dest && free_q.size() == 0);
    acc   = ren && !stall;
    rsp   = '0;
    entry = '0;
    if (acc) begin
      rsp.has_dest = req.has_dest;
      rsp.psrc1    = map_m[req.src1];
      rsp.psrc2    = map_m[req.src2];
      if (req.has_dest) begin
        rsp.pdest       = free_q.pop_front();
        rsp.pold        = map_m[req.dest];
        map_m[req.dest] = rsp.pdest;
      end
    end
    // the commit works on the queue as it stood before this rename
    if (com && retire_q.size() != 0) begin
      head = retire_q.pop_front();
      if (head.has_dest) begin
        free_q.push_back(head.pold);
      end
    end
    if (acc) begin
      entry.has_dest = req.has_dest;
      entry.pold     = rsp.pold;
      retire_q.push_back(entry);
    end
  endfunction

  // inputs and outputs are settled by the falling edge
  always @(negedge i_clk) begin
    logic        stall_e;
    logic        acc_e;
    rename_rsp_t rsp_e;
    if (!i_reset_n) begin
      reset_model();
      exp_valid = 1'b0;
    end else begin
      o_checks++;
      if (i_rsp_valid !== exp_valid) begin
        $display("Mismatch at %0t: o_rsp_valid expected %0b got %0b",
                 $time, exp_valid, i_rsp_valid);
        o_errors++;
      end else if (exp_valid && i_rsp !== exp_rsp) begin
        $display("Mismatch at %0t: o_rsp expected %h got %h", $time, exp_rsp, i_rsp);
        o_errors++;
      end
      model_step(i_rename, i_req, i_commit, stall_e, acc_e, rsp_e);
      if (i_stall !== stall_e) begin
        $display("Mismatch at %0t: o_stall expected %0b got %0b", $time, stall_e, i_stall);
        o_errors++;
      end
      exp_valid = acc_e;
      if (acc_e) begin
        exp_rsp = rsp_e;
      end
    end
  end

endmodule

// File: verif/rename_unit_props.sv
// Rename stage assertions
`timescale 1ns/1ps

module rename_unit_props (
  input logic i_clk,
  input logic i_reset_n,
  input logic i_rename,
  input logic i_stall,
  input logic i_rsp_valid,
  input logic i_fl_empty,
  input logic i_commit,
  input logic i_rq_empty,
  input logic i_free_valid
);

  int failures = 0;

  // a dropped request produces no response
  a_no_rsp_after_stall: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_rename && i_stall) |=> !i_rsp_valid)
    else begin
      $error("response issued for a stalled rename");
      failures++;
    end

  // an empty freelist that gets no id back stays empty unless something pops it
  a_no_pop_when_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_fl_empty && !i_free_valid) |=> i_fl_empty)
    else begin
      $error("freelist popped while empty");
      failures++;
    end

  // the queue stays empty after such a commit unless a rename went in alongside it
  a_no_commit_when_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_commit && i_rq_empty) |=> (i_rq_empty == !$past(i_rename && !i_stall)))
    else begin
      $error("commit honoured with an empty retire queue");
      failures++;
    end

endmodule

bind rename_unit rename_unit_props u_props (
  .i_clk        (i_clk),
  .i_reset_n    (i_reset_n),
  .i_rename     (i_rename),
  .i_stall      (o_stall),
  .i_rsp_valid  (o_rsp_valid),
  .i_fl_empty   (fl_empty),
  .i_commit     (i_commit),
  .i_rq_empty   (rq_empty),
  .i_free_valid (free_valid)
);

// File: verif/rename_unit_tb.sv
// Rename stage testbench
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_unit_tb
  import rename_pkg::*;
();

  localparam int FILL_CYCLES   = 18;
  localparam int COMMIT_CYCLES = 16;
  localparam int REUSE_CYCLES  = 20;
  localparam int RANDOM_CYCLES = 400;
  localparam int TOTAL_CYCLES  = 4 + FILL_CYCLES + 1 + COMMIT_CYCLES + REUSE_CYCLES
                                 + RANDOM_CYCLES + 4;
  localparam int TIMEOUT_NS    = (TOTAL_CYCLES + 100) * 10;

  logic        clk;
  logic        reset_n;
  logic        rename;
  rename_req_t req;
  logic        commit;
  logic        stall;
  logic        rsp_valid;
  rename_rsp_t rsp;
  int          errors;
  int          checks;
  logic [15:0] lfsr_state = 16'd14;

  tb_clock_gen u_clock (.o_clk(clk), .o_reset_n(reset_n));

  rename_unit DUT (
    .i_clk       (clk),
    .i_reset_n   (reset_n),
    .i_rename    (rename),
    .i_req       (req),
    .i_commit    (commit),
    .o_stall     (stall),
    .o_rsp_valid (rsp_valid),
    .o_rsp       (rsp)
  );

  rename_checker u_checker (
    .i_clk       (clk),
    .i_reset_n   (reset_n),
    .i_rename    (rename),
    .i_req       (req),
    .i_commit    (commit),
    .i_stall     (stall),
    .i_rsp_valid (rsp_valid),
    .i_rsp       (rsp),
    .o_errors    (errors),
    .o_checks    (checks)
  );

  // Galois LFSR, one step per bit handed out
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] val;
    logic        b;
    val = '0;
    for (int i = 0; i < n; i++) begin
      b          = lfsr_state[0];
      lfsr_state = (lfsr_state >> 1) ^ (b ? 16'hB400 : 16'h0000);
      val        = {val[14:0], b};
    end
    return val;
  endfunction

  function automatic rename_req_t make_req(input logic has_dest, input int dest,
                                           input int src1, input int src2);
    rename_req_t r;
    r.has_dest = has_dest;
    r.dest     = areg_t'(dest);
    r.src1     = areg_t'(src1);
    r.src2     = areg_t'(src2);
    return r;
  endfunction

  task automatic drive(input logic ren, input rename_req_t r, input logic com);
    @(posedge clk);
    rename <= ren;
    req    <= r;
    commit <= com;
  endtask

  initial begin
    rename_req_t r;
    logic        ren;
    logic        com;
    rename = 1'b0;
    req    = '0;
    commit = 1'b0;
    @(posedge reset_n);
    // src1 equals dest, so each lookup has to return the old mapping
    for (int k = 0; k < FILL_CYCLES; k++) begin
      drive(1'b1, make_req(1'b1, k % 16, k % 16, (k + 1) % 16), 1'b0);
    end
    // the retire queue is full, so even this one is held off
    drive(1'b1, make_req(1'b0, 0, 3, 4), 1'b0);
    for (int k = 0; k < COMMIT_CYCLES; k++) begin
      drive(1'b0, '0, 1'b1);
    end
    // released ids come back in the order they were committed
    for (int k = 0; k < REUSE_CYCLES; k++) begin
      drive(1'b1, make_req(1'b1, (k * 3) % 16, (k + 5) % 16, k % 16), 1'b0);
    end
    for (int k = 0; k < RANDOM_CYCLES; k++) begin
      ren        = (take_bits(2) != 0);
      r.has_dest = (take_bits(2) != 0);
      r.dest     = areg_t'(take_bits(4));
      r.src1     = areg_t'(take_bits(4));
      r.src2     = areg_t'(take_bits(4));
      com        = take_bits(1);
      drive(ren, r, com);
    end
    drive(1'b0, '0, 1'b0);
    repeat (3) @(posedge clk);
    $display("Checks: %0d cycles compared, %0d errors, %0d assertion failures",
             checks, errors, DUT.u_props.failures);
    if (errors == 0 && DUT.u_props.failures == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not end within %0d ns", TIMEOUT_NS);
    $display("Test failed");
    $finish;
  end

endmodule

// File: rename_unit.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/phys_freelist.sv
verilog/rename_map.sv
verilog/retire_queue.sv
verilog/rename_unit.sv
verif/tb_clock_gen.sv
verif/rename_checker.sv
verif/rename_unit_props.sv
verif/rename_unit_tb.sv
